// ==== compile.f ====
+incdir+tests
hdl/rv_pkg.sv
hdl/alu_dec.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/controller_multicycle.sv
hdl/datapath_multicycle.sv
hdl/rv_core_multicycle.sv
tests/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core_multicycle

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/alu_dec.sv
      - hdl/alu.sv
      - hdl/reg_file.sv
      - hdl/controller_multicycle.sv
      - hdl/datapath_multicycle.sv
      - hdl/rv_core_multicycle.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_core.sv

// ==== tests/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int L_ALU  = 4;
localparam int L_LD   = 5;
localparam int L_ST   = 4;
localparam int L_BR   = 3;
localparam int L_J    = 3;
localparam int L_JR   = 4;
localparam int L_SKIP = 0; // never retires

word_t     prog [$];
word_t     exp_pc [$];
int        exp_lat [$];
int        exp_rd [$];
word_t     exp_wd [$];
word_t     st_addr [$];
logic [3:0] st_be [$];
word_t     st_data [$];
word_t     fin_addr [$];
word_t     fin_data [$];

function automatic word_t enc_r(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_R_TYPE};
endfunction

function automatic word_t enc_i(int op, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic word_t enc_s(int f3, int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_S_TYPE};
endfunction

function automatic word_t enc_b(int f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_B_TYPE};
endfunction

function automatic word_t enc_j(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_J_TYPE};
endfunction

// one program word, its retire latency and its register write (rd 0 = none)
task automatic put(word_t w, int lat, int rd, word_t data);
    if (lat > 0) begin
        exp_pc.push_back(prog.size() * 4);
        exp_lat.push_back(lat);
    end
    if (rd > 0) begin
        exp_rd.push_back(rd);
        exp_wd.push_back(data);
    end
    prog.push_back(w);
endtask

task automatic expect_store(word_t addr, logic [3:0] be, word_t data);
    st_addr.push_back(addr);
    st_be.push_back(be);
    st_data.push_back(data);
endtask

task automatic expect_word(word_t addr, word_t data);
    fin_addr.push_back(addr);
    fin_data.push_back(data);
endtask

task automatic poison();
    put(enc_i(OP_I_TYPE, 0, 31, 0, 1), L_SKIP, 0, 0); // must be jumped over
endtask

task automatic build_program();
    put(enc_i(OP_I_TYPE, 0, 1, 0, 5), L_ALU, 1, 32'h0000_0005);
    put(enc_i(OP_I_TYPE, 0, 2, 0, -3), L_ALU, 2, 32'hffff_fffd);
    put(enc_r(0, 0, 3, 1, 2), L_ALU, 3, 32'h0000_0002);     // add
    put(enc_r(32, 0, 4, 2, 1), L_ALU, 4, 32'hffff_fff8);    // sub
    put(enc_r(0, 7, 5, 1, 2), L_ALU, 5, 32'h0000_0005);     // and
    put(enc_r(0, 6, 6, 1, 2), L_ALU, 6, 32'hffff_fffd);     // or
    put(enc_r(0, 4, 7, 1, 2), L_ALU, 7, 32'hffff_fff8);     // xor
    put(enc_r(0, 2, 8, 2, 1), L_ALU, 8, 32'h0000_0001);     // slt
    put(enc_r(0, 3, 9, 2, 1), L_ALU, 9, 32'h0000_0000);     // sltu
    put(enc_r(32, 5, 10, 4, 1), L_ALU, 10, 32'hffff_ffff);  // sra
    put(enc_r(0, 5, 11, 4, 1), L_ALU, 11, 32'h07ff_ffff);   // srl
    put(enc_r(0, 1, 12, 1, 1), L_ALU, 12, 32'h0000_00a0);   // sll
    put(enc_i(OP_I_TYPE, 1, 13, 2, 4), L_ALU, 13, 32'hffff_ffd0);
    put(enc_i(OP_I_TYPE, 5, 14, 4, 'h402), L_ALU, 14, 32'hffff_fffe); // srai
    put(enc_i(OP_I_TYPE, 5, 15, 4, 28), L_ALU, 15, 32'h0000_000f);
    put(enc_i(OP_I_TYPE, 2, 16, 2, -2), L_ALU, 16, 32'h0000_0001);
    put(enc_i(OP_I_TYPE, 3, 17, 1, -1), L_ALU, 17, 32'h0000_0001);
    put(enc_i(OP_I_TYPE, 4, 18, 1, 'hff), L_ALU, 18, 32'h0000_00fa);
    put(enc_i(OP_I_TYPE, 6, 19, 0, 'h200), L_ALU, 19, 32'h0000_0200); // data base
    put(enc_i(OP_I_TYPE, 7, 20, 2, 'hf0), L_ALU, 20, 32'h0000_00f0);
    put(enc_s(2, 4, 19, 0), L_ST, 0, 0);
    put(enc_s(0, 18, 19, 5), L_ST, 0, 0);
    put(enc_s(1, 13, 19, 10), L_ST, 0, 0);
    put(enc_s(2, 2, 19, 12), L_ST, 0, 0);
    put(enc_i(OP_I_TYPE_L, 0, 21, 19, 5), L_LD, 21, 32'hffff_fffa);
    put(enc_i(OP_I_TYPE_L, 4, 22, 19, 5), L_LD, 22, 32'h0000_00fa);
    put(enc_i(OP_I_TYPE_L, 1, 23, 19, 10), L_LD, 23, 32'hffff_ffd0);
    put(enc_i(OP_I_TYPE_L, 5, 24, 19, 10), L_LD, 24, 32'h0000_ffd0);
    put(enc_i(OP_I_TYPE_L, 2, 25, 19, 0), L_LD, 25, 32'hffff_fff8);
    put(enc_i(OP_I_TYPE_L, 0, 26, 19, 4), L_LD, 26, 32'h0000_007e);
    put(enc_b(0, 1, 2, 8), L_BR, 0, 0);     // beq not taken
    put(enc_b(0, 1, 1, 8), L_BR, 0, 0);
    poison();
    put(enc_b(1, 1, 1, 8), L_BR, 0, 0);     // bne not taken
    put(enc_b(1, 1, 2, 8), L_BR, 0, 0);
    poison();
    put(enc_b(4, 1, 2, 8), L_BR, 0, 0);     // blt not taken
    put(enc_b(4, 2, 1, 8), L_BR, 0, 0);
    poison();
    put(enc_b(5, 2, 1, 8), L_BR, 0, 0);     // bge not taken
    put(enc_b(5, 1, 2, 8), L_BR, 0, 0);
    poison();
    put(enc_b(6, 2, 1, 8), L_BR, 0, 0);     // bltu not taken
    put(enc_b(6, 1, 2, 8), L_BR, 0, 0);
    poison();
    put(enc_b(7, 1, 2, 8), L_BR, 0, 0);     // bgeu not taken
    put(enc_b(7, 2, 1, 8), L_BR, 0, 0);
    poison();
    put(enc_j(27, 12), L_J, 27, 32'h0000_00c4);
    poison();
    poison();
    put(enc_i(OP_I_TYPE, 0, 28, 0, 'he0), L_ALU, 28, 32'h0000_00e0);
    put(enc_i(OP_JALR, 0, 29, 28, 4), L_JR, 29, 32'h0000_00d4);
    poison();
    poison();
    poison();
    poison();
    put(enc_s(2, 27, 19, 16), L_ST, 0, 0);
    put(32'hffff_ffff, L_SKIP, 0, 0);       // illegal opcode
    expect_store(32'h0000_0200, 4'b1111, 32'hffff_fff8);
    expect_store(32'h0000_0205, 4'b0010, 32'h0000_fa00);
    expect_store(32'h0000_020a, 4'b1100, 32'hffd0_0000);
    expect_store(32'h0000_020c, 4'b1111, 32'hffff_fffd);
    expect_store(32'h0000_0210, 4'b1111, 32'h0000_00c4);
    expect_word(32'h0000_0200, 32'hffff_fff8);
    expect_word(32'h0000_0204, 32'hc0de_fa7e);
    expect_word(32'h0000_0208, 32'hffd0_827d);
    expect_word(32'h0000_020c, 32'hffff_fffd);
    expect_word(32'h0000_0210, 32'h0000_00c4);
endtask

`endif

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();
    localparam word_t RESET_PC    = 32'h0;
    localparam int    N_INSTR     = 47;
    localparam int    CYCLE_LIMIT = 3 + N_INSTR * 5 + 50;

    logic       clk = 1'b0; // no edge at time zero
    logic       rst;
    word_t      mem_rdata;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic [3:0] mem_be;
    logic       mem_we;
    logic       retire;
    word_t      retire_pc;
    rf_wr_s     rf_wr;
    logic       trap;

    word_t mem [0:255];
    int    cyc;
    int    ncyc;
    int    last_ret;
    int    n_ret;
    int    n_wr;
    int    n_st;
    logic  trapped;
    logic  was_rst;

    `include "tb_program.svh"

    rv_core_multicycle #(
        .RESET_PC (RESET_PC)
    ) i_rv_core_multicycle (
        .clk       (clk),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_be    (mem_be),
        .mem_we    (mem_we),
        .retire    (retire),
        .retire_pc (retire_pc),
        .rf_wr     (rf_wr),
        .trap      (trap)
    );

    task automatic stop_run(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic value_mismatch(string name, word_t got, word_t exp);
        stop_run($sformatf("ERROR %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    always #2 clk = ~clk;

    assign mem_rdata = mem[mem_addr[9:2]]; // word addressed

    always @(posedge clk) begin
        if (mem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_be[b]) begin
                    mem[mem_addr[9:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            stop_run("timeout: the program did not reach the trap");
        end
    end

    // outputs are sampled mid cycle
    always @(negedge clk) begin
        if (rst || was_rst) begin
            assert (!retire && !mem_we && !trap)
                else stop_run("retire, mem_we or trap active around reset");
            assert (mem_addr == RESET_PC)
                else value_mismatch("mem_addr", mem_addr, RESET_PC);
        end
        if (rst) begin
            last_ret = ncyc;
        end
        was_rst = rst;
        if (trapped) begin
            assert (trap && !retire && !rf_wr.en && !mem_we)
                else stop_run("core active or trap dropped after the illegal opcode");
        end
        if (retire) begin
            assert (n_ret < exp_pc.size())
                else stop_run("more instructions retired than expected");
            assert (retire_pc == exp_pc[n_ret])
                else value_mismatch("retire_pc", retire_pc, exp_pc[n_ret]);
            assert (ncyc - last_ret == exp_lat[n_ret])
                else value_mismatch("retire latency", ncyc - last_ret, exp_lat[n_ret]);
            last_ret = ncyc;
            n_ret++;
        end
        if (rf_wr.en) begin
            assert (n_wr < exp_rd.size())
                else stop_run("more register writes than expected");
            assert (rf_wr.rd == exp_rd[n_wr])
                else value_mismatch("rf_wr.rd", rf_wr.rd, exp_rd[n_wr]);
            assert (rf_wr.data == exp_wd[n_wr])
                else value_mismatch("rf_wr.data", rf_wr.data, exp_wd[n_wr]);
            n_wr++;
        end
        if (mem_we) begin
            assert (n_st < st_addr.size())
                else stop_run("more stores than expected");
            assert (mem_addr == st_addr[n_st])
                else value_mismatch("mem_addr", mem_addr, st_addr[n_st]);
            assert (mem_be == st_be[n_st])
                else value_mismatch("mem_be", mem_be, st_be[n_st]);
            assert (mem_wdata == st_data[n_st])
                else value_mismatch("mem_wdata", mem_wdata, st_data[n_st]);
            n_st++;
        end
        if (trap && !trapped) begin
            assert (n_ret == exp_pc.size())
                else stop_run("trap raised before all instructions retired");
            trapped = 1'b1;
        end
        ncyc++;
    end

    initial begin
        rst      = 1'b1;
        cyc      = 0;
        ncyc     = 0;
        last_ret = 0;
        n_ret    = 0;
        n_wr     = 0;
        n_st     = 0;
        trapped  = 1'b0;
        was_rst  = 1'b1;
        build_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i < prog.size()) ? prog[i] : {16'hc0de, i[7:0], ~i[7:0]};
        end
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        wait (trapped);
        repeat (8) @(posedge clk); // trap must hold
        assert (n_wr == exp_rd.size())
            else stop_run("not all expected register writes were seen");
        assert (n_st == st_addr.size())
            else stop_run("not all expected stores were seen");
        for (int k = 0; k < fin_addr.size(); k++) begin
            assert (mem[fin_addr[k][9:2]] == fin_data[k])
                else value_mismatch("mem word", mem[fin_addr[k][9:2]], fin_data[k]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== hdl/rv_core_multicycle.sv ====
`timescale 1ns/10ps

module rv_core_multicycle import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       rst,
    input  word_t      mem_rdata,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic [3:0] mem_be,
    output logic       mem_we,
    output logic       retire,
    output word_t      retire_pc,
    output rf_wr_s     rf_wr,
    output logic       trap
);
    ctrl_s      ctrl;
    word_t      instr;
    alu_flags_s alu_flags;

    controller_multicycle i_controller (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl),
        .retire    (retire),
        .trap      (trap)
    );

    datapath_multicycle #(
        .RESET_PC (RESET_PC)
    ) i_datapath (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .instr     (instr),
        .alu_flags (alu_flags),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_be    (mem_be),
        .mem_we    (mem_we),
        .retire_pc (retire_pc),
        .rf_wr     (rf_wr)
    );

endmodule

// ==== hdl/datapath_multicycle.sv ====
`timescale 1ns/10ps

module datapath_multicycle import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       rst,
    input  ctrl_s      ctrl,
    input  word_t      mem_rdata,
    output word_t      instr,
    output alu_flags_s alu_flags,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic [3:0] mem_be,
    output logic       mem_we,
    output word_t      retire_pc,
    output rf_wr_s     rf_wr
);
    word_t       pc;
    word_t       old_pc;
    word_t       ir;
    word_t       mdr;
    word_t       alu_out;
    word_t       imm;
    word_t       src_a;
    word_t       src_b;
    word_t       alu_y;
    word_t       rd1;
    word_t       rd2;
    word_t       ld_data;
    word_t       result;
    word_t       rf_wd;
    logic [1:0]  byte_off;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    function automatic word_t pick_src(alu_src_e sel, word_t pc_v, word_t old_v,
                                       word_t r1, word_t r2, word_t imm_v);
        case (sel)
            ALU_SRC_PC:      return pc_v;
            ALU_SRC_PC_OLD:  return old_v;
            ALU_SRC_REG_1:   return r1;
            ALU_SRC_REG_2:   return r2;
            ALU_SRC_EXT_IMM: return imm_v;
            ALU_SRC_4:       return 32'd4;
            default:         return '0;
        endcase
    endfunction

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
            ir <= '0;
        end else begin
            if (ctrl.en_oldpc_r) begin
                pc <= alu_y;                       // pc + 4 in fetch
            end else if (ctrl.en_npc_r) begin
                pc <= {alu_out[31:1], 1'b0};       // jump or branch target
            end
            if (ctrl.en_ir) begin
                ir <= mem_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.en_oldpc_r) begin
            old_pc <= pc;
        end
        mdr     <= mem_rdata;
        alu_out <= alu_y;
    end

    always_comb begin
        case (ctrl.imm_src)
            IMM_SRC_ITYPE:  imm = {{20{ir[31]}}, ir[31:20]};
            IMM_SRC_ITYPE2: imm = {27'b0, ir[24:20]};
            IMM_SRC_STYPE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            IMM_SRC_BTYPE:  imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            IMM_SRC_JTYPE:  imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            default:        imm = '0;
        endcase
    end

    reg_file i_reg_file (
        .clk (clk),
        .rst (rst),
        .ra1 (ir[19:15]),
        .ra2 (ir[24:20]),
        .wa  (ir[11:7]),
        .we  (ctrl.rf_we),
        .wd  (rf_wd),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    assign src_a = pick_src(ctrl.alu_src_a, pc, old_pc, rd1, rd2, imm);
    assign src_b = pick_src(ctrl.alu_src_b, pc, old_pc, rd1, rd2, imm);

    alu i_alu (
        .a     (src_a),
        .b     (src_b),
        .op    (ctrl.alu_ctrl),
        .y     (alu_y),
        .flags (alu_flags)
    );

    assign byte_off = alu_out[1:0];
    assign ld_byte  = mdr[{byte_off, 3'b000} +: 8];
    assign ld_half  = byte_off[1] ? mdr[31:16] : mdr[15:0];

    always_comb begin
        case (ctrl.dt)
            MEM_DT_BYTE:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            MEM_DT_UBYTE: ld_data = {24'b0, ld_byte};
            MEM_DT_HALF:  ld_data = {{16{ld_half[15]}}, ld_half};
            MEM_DT_UHALF: ld_data = {16'b0, ld_half};
            default:      ld_data = mdr;
        endcase
    end

    always_comb begin
        case (ctrl.dt)
            MEM_DT_BYTE: begin
                mem_wdata = {24'b0, rd2[7:0]} << {byte_off, 3'b000};
                mem_be    = 4'b0001 << byte_off;
            end
            MEM_DT_HALF: begin
                mem_wdata = {16'b0, rd2[15:0]} << {byte_off[1], 4'b0000};
                mem_be    = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                mem_wdata = rd2;
                mem_be    = 4'b1111;
            end
        endcase
    end

    always_comb begin
        case (ctrl.res_src)
            RES_SRC_ALU_OUT: result = alu_out;
            RES_SRC_MEM:     result = ld_data;
            default:         result = '0;
        endcase
    end

    assign rf_wd     = (ctrl.rf_wd_src == RF_WD_SRC_PC) ? pc : result; // pc holds old pc + 4
    assign mem_addr  = ctrl.m_addr_src ? alu_out : pc;
    assign mem_we    = ctrl.m_we;
    assign instr     = ir;
    assign retire_pc = old_pc;
    assign rf_wr     = '{en: ctrl.rf_we, rd: ir[11:7], data: rf_wd};

endmodule

// ==== hdl/controller_multicycle.sv ====
`timescale 1ns/10ps

module controller_multicycle import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_t      instr,
    input  alu_flags_s alu_flags,
    output ctrl_s      ctrl,
    output logic       retire,
    output logic       trap
);
    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        MEM_ADDR,
        MEM_READ,
        MEM_WRITE,
        MEM_W_RF,
        EXEC_R,
        ALU_W_RF,
        BRANCH,
        EXEC_I,
        ALU_W_PCN,
        EXEC_I_JALR,
        EXEC_J,
        ERROR
    } state_e;

    localparam ctrl_s CTRL_IDLE = '{
        rf_we:      1'b0,
        m_we:       1'b0,
        alu_src_a:  ALU_SRC_NONE,
        alu_src_b:  ALU_SRC_NONE,
        res_src:    RES_SRC_NONE,
        imm_src:    IMM_SRC_NONE,
        rf_wd_src:  RF_WD_SRC_RES,
        alu_ctrl:   ALU_OP_NONE,
        dt:         MEM_DT_NONE,
        en_ir:      1'b0,
        en_npc_r:   1'b0,
        en_oldpc_r: 1'b0,
        m_addr_src: 1'b0
    };

    state_e     cs;
    state_e     ns;
    opcode_t    op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    dec_op;
    mem_dt_e    mem_dt;
    imm_src_e   alu_i_imm;
    logic       take_branch;

    assign op     = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    alu_dec i_alu_dec (
        .op     (op),
        .funct3 (funct3),
        .funct7 (funct7),
        .alu_op (dec_op)
    );

    always_comb begin
        case (cs)
            FETCH: ns = DECODE;
            DECODE: begin
                case (op)
                    OP_R_TYPE:   ns = EXEC_R;
                    OP_I_TYPE:   ns = EXEC_I;
                    OP_JALR:     ns = EXEC_I_JALR;
                    OP_I_TYPE_L: ns = MEM_ADDR;
                    OP_S_TYPE:   ns = MEM_ADDR;
                    OP_B_TYPE:   ns = BRANCH;
                    OP_J_TYPE:   ns = EXEC_J;
                    default:     ns = ERROR;
                endcase
            end
            MEM_ADDR:       ns = (op == OP_I_TYPE_L) ? MEM_READ : MEM_WRITE;
            MEM_READ:       ns = MEM_W_RF;
            EXEC_R, EXEC_I: ns = ALU_W_RF;
            EXEC_I_JALR:    ns = ALU_W_PCN;
            MEM_WRITE, MEM_W_RF, ALU_W_RF, ALU_W_PCN, BRANCH, EXEC_J: ns = FETCH;
            default:        ns = ERROR; // sticky
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cs <= FETCH;
        end else begin
            cs <= ns;
        end
    end

    assign alu_i_imm = (funct3 == 3'b001 || funct3 == 3'b101) ? IMM_SRC_ITYPE2 : IMM_SRC_ITYPE;

    always_comb begin
        case (funct3)
            3'b000:  mem_dt = MEM_DT_BYTE;
            3'b001:  mem_dt = MEM_DT_HALF;
            3'b010:  mem_dt = MEM_DT_WORD;
            3'b100:  mem_dt = MEM_DT_UBYTE;
            3'b101:  mem_dt = MEM_DT_UHALF;
            default: mem_dt = MEM_DT_NONE;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  take_branch = alu_flags.zero;                   // beq
            3'b001:  take_branch = ~alu_flags.zero;                  // bne
            3'b100:  take_branch = alu_flags.neg ^ alu_flags.ov;     // blt
            3'b101:  take_branch = ~(alu_flags.neg ^ alu_flags.ov);  // bge
            3'b110:  take_branch = ~alu_flags.cout;                  // bltu, borrow
            3'b111:  take_branch = alu_flags.cout;                   // bgeu
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = CTRL_IDLE;
        case (cs)
            FETCH: begin
                ctrl.alu_src_a  = ALU_SRC_PC;
                ctrl.alu_src_b  = ALU_SRC_4;
                ctrl.alu_ctrl   = ALU_OP_ADD;
                ctrl.dt         = MEM_DT_WORD;
                ctrl.en_ir      = 1'b1;
                ctrl.en_oldpc_r = 1'b1; // pc <= pc + 4
            end
            DECODE: begin
                ctrl.alu_src_a = ALU_SRC_PC_OLD; // speculative target
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
                ctrl.imm_src   = (op == OP_J_TYPE) ? IMM_SRC_JTYPE : IMM_SRC_BTYPE;
                ctrl.alu_ctrl  = ALU_OP_ADD;
            end
            MEM_ADDR, MEM_READ, MEM_WRITE, MEM_W_RF: begin
                ctrl.alu_src_a  = ALU_SRC_REG_1; // hold address in alu_out
                ctrl.alu_src_b  = ALU_SRC_EXT_IMM;
                ctrl.imm_src    = (op == OP_I_TYPE_L) ? IMM_SRC_ITYPE : IMM_SRC_STYPE;
                ctrl.alu_ctrl   = ALU_OP_ADD;
                ctrl.dt         = mem_dt;
                ctrl.res_src    = RES_SRC_MEM;
                ctrl.m_addr_src = (cs != MEM_ADDR);
                ctrl.m_we       = (cs == MEM_WRITE);
                ctrl.rf_we      = (cs == MEM_W_RF);
            end
            EXEC_R: begin
                ctrl.alu_src_a = ALU_SRC_REG_1;
                ctrl.alu_src_b = ALU_SRC_REG_2;
                ctrl.alu_ctrl  = dec_op;
            end
            EXEC_I: begin
                ctrl.alu_src_a = ALU_SRC_REG_1;
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
                ctrl.imm_src   = alu_i_imm;
                ctrl.alu_ctrl  = dec_op;
            end
            ALU_W_RF: begin
                ctrl.rf_we   = 1'b1;
                ctrl.res_src = RES_SRC_ALU_OUT;
            end
            EXEC_I_JALR: begin
                ctrl.alu_src_a = ALU_SRC_REG_1;
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
                ctrl.imm_src   = IMM_SRC_ITYPE;
                ctrl.alu_ctrl  = ALU_OP_ADD;
                ctrl.rf_we     = 1'b1;
                ctrl.rf_wd_src = RF_WD_SRC_PC;
            end
            ALU_W_PCN: ctrl.en_npc_r = 1'b1;
            BRANCH: begin
                ctrl.alu_src_a = ALU_SRC_REG_1;
                ctrl.alu_src_b = ALU_SRC_REG_2;
                ctrl.alu_ctrl  = dec_op;
                ctrl.en_npc_r  = take_branch;
            end
            EXEC_J: begin
                ctrl.en_npc_r  = 1'b1;
                ctrl.rf_we     = 1'b1;
                ctrl.rf_wd_src = RF_WD_SRC_PC;
            end
            default: ctrl = CTRL_IDLE;
        endcase
    end

    assign retire = cs inside {MEM_WRITE, MEM_W_RF, ALU_W_RF, ALU_W_PCN, BRANCH, EXEC_J};
    assign trap   = (cs == ERROR);

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    input  reg_idx_t wa,
    input  logic     we,
    input  word_t    wd,
    output word_t    rd1,
    output word_t    rd2
);
    word_t regs [31:1]; // x0 not stored

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps

module alu import rv_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    output word_t      y,
    output alu_flags_s flags
);
    logic        sub;
    word_t       b_eff;
    logic [32:0] sum;

    assign sub   = (op == ALU_OP_SUB) || (op == ALU_OP_SLT) || (op == ALU_OP_SLTU);
    assign b_eff = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'b0, sub};

    assign flags.neg  = sum[31];
    assign flags.zero = (sum[31:0] == '0);
    assign flags.cout = sum[32];
    assign flags.ov   = (a[31] == b_eff[31]) && (sum[31] != a[31]); // signed overflow

    always_comb begin
        case (op)
            ALU_OP_ADD,
            ALU_OP_SUB:  y = sum[31:0];
            ALU_OP_AND:  y = a & b;
            ALU_OP_OR:   y = a | b;
            ALU_OP_XOR:  y = a ^ b;
            ALU_OP_SLL:  y = a << b[4:0];
            ALU_OP_SRL:  y = a >> b[4:0];
            ALU_OP_SRA:  y = word_t'($signed(a) >>> b[4:0]);
            ALU_OP_SLT:  y = {31'b0, flags.neg ^ flags.ov};
            ALU_OP_SLTU: y = {31'b0, ~flags.cout};
            default:     y = '0;
        endcase
    end

endmodule

// ==== hdl/alu_dec.sv ====
`timescale 1ns/10ps

module alu_dec import rv_pkg::*; (
    input  opcode_t    op,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output alu_op_e    alu_op
);
    logic is_r;

    assign is_r = (op == OP_R_TYPE);

    always_comb begin
        alu_op = ALU_OP_ADD;
        if (op == OP_R_TYPE || op == OP_I_TYPE) begin
            case (funct3)
                3'b000: begin
                    alu_op = (is_r && funct7[5]) ? ALU_OP_SUB : ALU_OP_ADD; // no subi
                end
                3'b001: alu_op = ALU_OP_SLL;
                3'b010: alu_op = ALU_OP_SLT;
                3'b011: alu_op = ALU_OP_SLTU;
                3'b100: alu_op = ALU_OP_XOR;
                3'b101: alu_op = funct7[5] ? ALU_OP_SRA : ALU_OP_SRL;
                3'b110: alu_op = ALU_OP_OR;
                default: alu_op = ALU_OP_AND;
            endcase
        end else if (op == OP_B_TYPE) begin
            alu_op = ALU_OP_SUB; // compare via flags
        end
    end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    localparam opcode_t OP_R_TYPE   = 7'b0110011;
    localparam opcode_t OP_I_TYPE   = 7'b0010011;
    localparam opcode_t OP_I_TYPE_L = 7'b0000011; // loads
    localparam opcode_t OP_S_TYPE   = 7'b0100011;
    localparam opcode_t OP_B_TYPE   = 7'b1100011;
    localparam opcode_t OP_J_TYPE   = 7'b1101111; // jal
    localparam opcode_t OP_JALR     = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_XOR,
        ALU_OP_SLL,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_SRC_PC,
        ALU_SRC_PC_OLD,
        ALU_SRC_REG_1,
        ALU_SRC_REG_2,
        ALU_SRC_EXT_IMM,
        ALU_SRC_4,
        ALU_SRC_NONE
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_SRC_NONE,
        IMM_SRC_ITYPE,
        IMM_SRC_ITYPE2, // shamt only
        IMM_SRC_STYPE,
        IMM_SRC_BTYPE,
        IMM_SRC_JTYPE
    } imm_src_e;

    typedef enum logic [1:0] {
        RES_SRC_ALU_OUT,
        RES_SRC_MEM,
        RES_SRC_NONE
    } res_src_e;

    typedef enum logic {
        RF_WD_SRC_RES,
        RF_WD_SRC_PC    // link address
    } rf_wd_src_e;

    typedef enum logic [2:0] {
        MEM_DT_BYTE,
        MEM_DT_HALF,
        MEM_DT_WORD,
        MEM_DT_UBYTE,
        MEM_DT_UHALF,
        MEM_DT_NONE
    } mem_dt_e;

    typedef struct packed {
        logic neg;
        logic zero;
        logic cout;     // no borrow on sub
        logic ov;
    } alu_flags_s;

    typedef struct packed {
        logic       rf_we;
        logic       m_we;
        alu_src_e   alu_src_a;
        alu_src_e   alu_src_b;
        res_src_e   res_src;
        imm_src_e   imm_src;
        rf_wd_src_e rf_wd_src;
        alu_op_e    alu_ctrl;
        mem_dt_e    dt;
        logic       en_ir;
        logic       en_npc_r;
        logic       en_oldpc_r;
        logic       m_addr_src;
    } ctrl_s;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    data;
    } rf_wr_s;

endpackage
